// File: rtl/fetch_defs.svh
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// fetch front sizes and constants
//////////////////////////////////////////////////////////////////////

// address and instruction width.
`define FETCH_XLEN 32

// direct-mapped, one word per line.
`define ICACHE_LINES 16

// model memory, byte addresses below ROM_WORDS*4.
`define ROM_WORDS 256
`define ROM_LATENCY 3
`define ROM_PATTERN 32'hA5A5_0000

`define FETCH_RESET_PC 32'h0000_0000

`endif

// File: rtl/fetch_pkg.sv
`include "fetch_defs.svh"

package fetch_pkg;

    typedef logic [`FETCH_XLEN-1:0] word_t;

    // axi read response codes.
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_t;

    // fetch unit FSM.
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        CHECK = 2'b01,
        BUSY  = 2'b10
    } ifu_state_t;

endpackage

// File: rtl/ifu.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module ifu (
    input  logic                 clk,
    input  logic                 rst,
    input  fetch_pkg::word_t     pc,
    output logic                 ifu_valid,
    output fetch_pkg::word_t     inst,

    output fetch_pkg::word_t     araddr,
    output logic                 arvalid,
    input  logic                 arready,

    input  fetch_pkg::word_t     rdata,
    input  fetch_pkg::axi_resp_t rresp,
    input  logic                 rvalid,
    output logic                 rready,

    input  fetch_pkg::word_t     icache_data,
    input  logic                 icache_hit,
    input  logic                 icache_ready,
    input  logic                 mem_req,
    output logic                 icache_req,
    output logic                 mem_ready
);
    import fetch_pkg::*;

    ifu_state_t state, next_state;
    word_t      last_pc;
    logic       hit_reg;     // cache hit, one cycle late.
    logic       pc_changed;
    logic       fetch_done;

    assign mem_ready  = rvalid && (rresp == OKAY);
    assign pc_changed = (pc != last_pc);
    assign fetch_done = icache_ready && mem_ready && rready;

    always_comb begin
        case (state)
            IDLE:    next_state = pc_changed ? CHECK : IDLE;
            CHECK:   next_state = mem_req ? BUSY : (hit_reg ? IDLE : CHECK);
            BUSY:    next_state = fetch_done ? IDLE : BUSY;
            default: next_state = IDLE;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= IDLE;
            last_pc    <= `FETCH_RESET_PC;
            hit_reg    <= 1'b0;
            icache_req <= 1'b0;
            ifu_valid  <= 1'b0;
            arvalid    <= 1'b0;
            rready     <= 1'b0;
        end else begin
            state      <= next_state;
            hit_reg    <= icache_hit;
            icache_req <= (state == IDLE) && pc_changed;  // one-cycle pulse.
            ifu_valid  <= 1'b0;
            case (state)
                IDLE: begin
                    if (pc_changed) begin
                        last_pc <= pc;
                    end
                end
                CHECK: begin
                    if (hit_reg) begin
                        ifu_valid <= 1'b1;
                    end else if (mem_req) begin
                        arvalid <= 1'b1;  // miss, go to memory.
                    end
                end
                BUSY: begin
                    if (arvalid && arready) begin
                        arvalid <= 1'b0;
                        rready  <= 1'b1;
                    end
                    if (fetch_done) begin
                        ifu_valid <= 1'b1;
                        rready    <= 1'b0;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // instruction and read address.
    always_ff @(posedge clk) begin
        if (state == CHECK) begin
            araddr <= pc;
        end
        if ((state == CHECK) && hit_reg) begin
            inst <= icache_data;
        end else if ((state == BUSY) && fetch_done) begin
            inst <= rdata;
        end
    end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr));

    a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
        ifu_valid |=> !ifu_valid);

endmodule

// File: rtl/icache.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module icache (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::word_t pc,
    input  logic             icache_req,
    input  logic             mem_ready,
    input  logic             rready,
    input  fetch_pkg::word_t rdata,
    output logic             icache_hit,
    output fetch_pkg::word_t icache_data,
    output logic             icache_ready,
    output logic             mem_req
);
    import fetch_pkg::*;

    localparam int IDX_W = $clog2(`ICACHE_LINES);
    localparam int TAG_W = `FETCH_XLEN - IDX_W - 2;

    //////////////////////////////////////////////////////////////////////
    // line storage
    //////////////////////////////////////////////////////////////////////

    logic [`ICACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]         tag_mem  [`ICACHE_LINES];
    word_t                    data_mem [`ICACHE_LINES];

    logic             lookup_q;  // request seen last cycle.
    logic [IDX_W-1:0] idx_q;     // also the refill target.
    logic [TAG_W-1:0] tag_q;
    logic             pending;
    logic             line_hit;
    logic             fill;

    assign line_hit     = valid_q[idx_q] && (tag_mem[idx_q] == tag_q);
    assign fill         = pending && mem_ready && rready;  // accepted OKAY beat.
    assign mem_req      = pending;
    assign icache_ready = pending;

    //////////////////////////////////////////////////////////////////////
    // lookup and refill control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q    <= '0;
            lookup_q   <= 1'b0;
            icache_hit <= 1'b0;
            pending    <= 1'b0;
        end else begin
            lookup_q   <= icache_req;
            icache_hit <= lookup_q && line_hit;
            if (lookup_q && !line_hit) begin
                pending <= 1'b1;
            end else if (fill) begin
                pending <= 1'b0;
            end
            if (fill) begin
                valid_q[idx_q] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (icache_req) begin
            idx_q <= pc[IDX_W+1:2];
            tag_q <= pc[`FETCH_XLEN-1:IDX_W+2];
        end
        if (lookup_q) begin
            icache_data <= data_mem[idx_q];
        end
        if (fill) begin
            tag_mem[idx_q]  <= tag_q;
            data_mem[idx_q] <= rdata;
        end
    end

    // the fetch unit must wait out a refill.
    a_no_req_in_refill: assert property (@(posedge clk) disable iff (rst)
        icache_req |-> !pending);

endmodule

// File: rtl/inst_rom.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module inst_rom (
    input  logic                 clk,
    input  logic                 rst,
    input  fetch_pkg::word_t     araddr,
    input  logic                 arvalid,
    output logic                 arready,
    output fetch_pkg::word_t     rdata,
    output fetch_pkg::axi_resp_t rresp,
    output logic                 rvalid,
    input  logic                 rready
);
    import fetch_pkg::*;

    localparam int    CNT_W     = $clog2(`ROM_LATENCY + 1);
    localparam word_t ROM_BYTES = `ROM_WORDS * 4;

    logic             busy;
    logic [CNT_W-1:0] cnt;
    word_t            addr_q;
    logic             fire;

    assign arready = !busy;  // one address at a time.
    assign fire    = busy && !rvalid && (cnt == CNT_W'(1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy   <= 1'b0;
            cnt    <= '0;
            rvalid <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                busy <= 1'b1;
                cnt  <= CNT_W'(`ROM_LATENCY);
            end else if (busy && !rvalid) begin
                cnt <= cnt - CNT_W'(1);
                if (fire) begin
                    rvalid <= 1'b1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
                busy   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            addr_q <= araddr;
        end
        if (fire) begin
            rdata <= (addr_q < ROM_BYTES) ? (addr_q ^ `ROM_PATTERN) : '0;
            rresp <= (addr_q < ROM_BYTES) ? OKAY : DECERR;  // decode error past the end.
        end
    end

    a_r_hold: assert property (@(posedge clk) disable iff (rst)
        rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::word_t pc,
    output logic             ifu_valid,
    output fetch_pkg::word_t inst
);
    import fetch_pkg::*;

    // read channel.
    word_t     araddr;
    logic      arvalid;
    logic      arready;
    word_t     rdata;
    axi_resp_t rresp;
    logic      rvalid;
    logic      rready;

    // cache link.
    word_t     icache_data;
    logic      icache_hit;
    logic      icache_ready;
    logic      mem_req;
    logic      icache_req;
    logic      mem_ready;

    ifu u_ifu (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .ifu_valid    (ifu_valid),
        .inst         (inst),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .icache_data  (icache_data),
        .icache_hit   (icache_hit),
        .icache_ready (icache_ready),
        .mem_req      (mem_req),
        .icache_req   (icache_req),
        .mem_ready    (mem_ready)
    );

    icache u_icache (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .icache_req   (icache_req),
        .mem_ready    (mem_ready),
        .rready       (rready),
        .rdata        (rdata),
        .icache_hit   (icache_hit),
        .icache_data  (icache_data),
        .icache_ready (icache_ready),
        .mem_req      (mem_req)
    );

    inst_rom u_inst_rom (
        .clk     (clk),
        .rst     (rst),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

endmodule

// File: testbench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;  // released off the edge.
    end

endmodule

// File: testbench/tb_fetch.sv
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_fetch;
    import fetch_pkg::*;

    localparam int CLK_PERIOD      = 10;
    localparam int HIT_CYCLES      = 4;
    localparam int RANDOM_FETCHES  = 150;
    localparam int HANG_WINDOW     = 20 + `ROM_LATENCY;
    localparam int WATCHDOG_CYCLES = 200 * (8 + `ROM_LATENCY) + HANG_WINDOW + 100;
    localparam int TAG_W           = `FETCH_XLEN - 6;

    logic  clk;
    logic  rst;
    word_t pc;
    logic  ifu_valid;
    word_t inst;

    // reference copy of the cache tags.
    bit               model_valid [`ICACHE_LINES];
    logic [TAG_W-1:0] model_tag   [`ICACHE_LINES];

    word_t      last_pc;
    logic       hang_window;
    int         fetches;
    int         hits;
    int         err_value;
    int         err_latency;
    int         err_hang;
    ifu_state_t dut_state;

    tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(5)) u_clock (
        .clk (clk),
        .rst (rst)
    );

    fetch_top uut (
        .clk       (clk),
        .rst       (rst),
        .pc        (pc),
        .ifu_valid (ifu_valid),
        .inst      (inst)
    );

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // pc is still held on the edge after the pulse.
    a_inst_rule: assert property (@(posedge clk) disable iff (rst)
        ifu_valid |-> (inst == (pc ^ `ROM_PATTERN)))
    else begin
        err_value++;
        $display("ERROR %0t: inst 0x%08h for pc 0x%08h, expected 0x%08h",
            $time, inst, pc, pc ^ `ROM_PATTERN);
    end

    a_no_valid_out_of_range: assert property (@(posedge clk) disable iff (rst)
        hang_window |-> !ifu_valid)
    else begin
        err_hang++;
        $display("ERROR %0t: ifu_valid raised for out-of-range pc 0x%08h", $time, pc);
    end

    function automatic bit predict_hit(input word_t addr);
        return model_valid[addr[5:2]] && (model_tag[addr[5:2]] == addr[`FETCH_XLEN-1:6]);
    endfunction

    task automatic record_line(input word_t addr);
        model_valid[addr[5:2]] = 1'b1;
        model_tag[addr[5:2]]   = addr[`FETCH_XLEN-1:6];
    endtask

    // half of the draws stay low so lines get reused.
    function automatic word_t random_addr();
        int unsigned span;
        span = ($urandom % 2 == 0) ? 32 : `ROM_WORDS;
        return word_t'(($urandom % span) * 4);
    endfunction

    task automatic report_counts();
        $display("fetches %0d, hits %0d, errors: value %0d, latency %0d, hang %0d",
            fetches, hits, err_value, err_latency, err_hang);
    endtask

    // entered and left 1 ns after a rising edge.
    task automatic fetch(input word_t addr, input bit exp_hit);
        int lat;
        lat = 0;
        pc  = addr;
        @(posedge clk);  // changed pc sampled here.
        do begin
            @(posedge clk);
            #1;
            lat++;
        end while (!ifu_valid);
        a_latency: assert (exp_hit ? (lat == HIT_CYCLES) : (lat > HIT_CYCLES))
        else begin
            err_latency++;
            $display("ERROR %0t: pc 0x%08h took %0d cycles, expected %s",
                $time, addr, lat, exp_hit ? "a 4-cycle hit" : "a miss over 4 cycles");
        end
        record_line(addr);
        last_pc = addr;
        fetches++;
        if (exp_hit) begin
            hits++;
        end
        @(posedge clk);
        #1;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        word_t addr;
        pc          = '0;
        last_pc     = `FETCH_RESET_PC;
        hang_window = 1'b0;
        fetches     = 0;
        hits        = 0;
        err_value   = 0;
        err_latency = 0;
        err_hang    = 0;
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            model_valid[i] = 1'b0;
        end
        void'($urandom(60));

        wait (rst === 1'b0);
        @(posedge clk);
        #1;

        fetch(32'h0000_0100, 1'b0);  // cold line.
        fetch(32'h0000_0104, 1'b0);
        fetch(32'h0000_0100, 1'b1);

        // 0x140 shares index 0 with 0x100.
        fetch(32'h0000_0140, 1'b0);
        fetch(32'h0000_0100, 1'b0);
        fetch(32'h0000_0104, 1'b1);  // neighbour untouched.

        for (int i = 0; i < RANDOM_FETCHES; i++) begin
            do begin
                addr = random_addr();
            end while (addr == last_pc);
            fetch(addr, predict_hit(addr));
        end

        // decode error, this fetch never ends.
        pc          = word_t'(`ROM_WORDS * 4);
        hang_window = 1'b1;
        repeat (HANG_WINDOW + 1) @(posedge clk);
        #1;
        hang_window = 1'b0;

        report_counts();
        if (err_value + err_latency + err_hang == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        dut_state = uut.u_ifu.state;
        $display("run timed out after %0d cycles, fetch unit stuck in state %s",
            WATCHDOG_CYCLES, dut_state.name());
        report_counts();
        $display("Checks failed");
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
rtl/fetch_pkg.sv
rtl/ifu.sv
rtl/icache.sv
rtl/inst_rom.sv
rtl/fetch_top.sv
testbench/tb_clock.sv
testbench/tb_fetch.sv

// File: run.sh
#!/bin/sh
# build and run the fetch front testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_fetch -f list.f \
    -Mdir obj_dir -o sim_fetch

./obj_dir/sim_fetch > sim.log 2>&1
cat sim.log

if grep -q "Checks failed" sim.log; then
    echo "simulation failed, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
